// File: src/dsp_seq_pkg.sv
package dsp_seq_pkg;

    // Bus widths and memory size
    localparam int addr_w    = 16;
    localparam int word_w    = 16;
    localparam int rom_depth = 4096;
    localparam int rom_aw    = $clog2(rom_depth);

    // Opcodes in bits 15:12
    localparam int op_hi = 15;
    localparam int op_lo = 12;
    localparam logic [3:0] op_nop    = 4'h0;
    localparam logic [3:0] op_goto   = 4'h1;
    localparam logic [3:0] op_call   = 4'h2;
    localparam logic [3:0] op_branch = 4'h3;
    localparam logic [3:0] op_load   = 4'h4;
    localparam logic [3:0] op_ptread = 4'h5;

    // Branch sub-codes of op_branch, bits 10:8
    localparam int br_hi = 10;
    localparam int br_lo = 8;
    localparam logic [2:0] br_ret     = 3'd0;
    localparam logic [2:0] br_iret    = 3'd1;
    localparam logic [2:0] br_goto_pt = 3'd2;
    localparam logic [2:0] br_call_pt = 3'd3;

    // Register selectors of op_load, bits 11:10
    localparam int rsel_hi = 11;
    localparam int rsel_lo = 10;
    localparam logic [1:0] reg_pt = 2'd0;
    localparam logic [1:0] reg_pr = 2'd1;
    localparam logic [1:0] reg_pi = 2'd2;
    localparam logic [1:0] reg_i  = 2'd3;

    // Immediate, jump field and step register widths
    localparam int imm_w  = 10;
    localparam int ja_w   = 12;
    localparam int step_w = 12;

    // Post-increment select in op_ptread
    localparam int istep_bit = 0;

    // Fixed addresses
    localparam logic [addr_w-1:0] irq_vector = 16'd1;
    localparam logic [addr_w-1:0] reset_pc   = 16'd0;

endpackage

// File: src/seq_ctl_if.sv
`timescale 1ns/1ps

interface seq_ctl_if;

    // Control strobes, one per decoded instruction
    logic goto_ja;
    logic call_ja;
    logic ret;
    logic iret;
    logic goto_pt;
    logic call_pt;
    logic load_en;
    logic pt_read;

    // Pointer step select, only meaningful with pt_read
    logic istep;

    // Instruction fields
    logic [dsp_seq_pkg::ja_w-1:0]   ja_field;
    logic [1:0]                     r_field;
    logic [dsp_seq_pkg::word_w-1:0] imm;

    modport dec (
        output goto_ja, call_ja, ret, iret, goto_pt, call_pt,
        output load_en, pt_read, istep,
        output ja_field, r_field, imm
    );

    modport aau (
        input goto_ja, call_ja, ret, iret, goto_pt, call_pt,
        input load_en, pt_read, istep,
        input ja_field, r_field, imm
    );

endinterface

// File: src/seq_prog_rom.sv
`timescale 1ns/1ps

module seq_prog_rom (
    input  logic [dsp_seq_pkg::addr_w-1:0] inst_addr,
    output logic [dsp_seq_pkg::word_w-1:0] inst_data,
    input  logic [dsp_seq_pkg::addr_w-1:0] tab_addr,
    output logic [dsp_seq_pkg::word_w-1:0] tab_data
);

    // Shared program and table storage
    logic [dsp_seq_pkg::word_w-1:0] mem [dsp_seq_pkg::rom_depth];

    logic [dsp_seq_pkg::rom_aw-1:0] inst_idx;
    logic [dsp_seq_pkg::rom_aw-1:0] tab_idx;

    initial begin
        $readmemh("program.hex", mem);
    end

    // Upper address bits are ignored so reads wrap at the depth
    assign inst_idx = inst_addr[dsp_seq_pkg::rom_aw-1:0];
    assign tab_idx  = tab_addr[dsp_seq_pkg::rom_aw-1:0];

    // Instruction port
    assign inst_data = mem[inst_idx];

    // Table port through the pointer
    assign tab_data = mem[tab_idx];

endmodule

// File: src/seq_decode.sv
`timescale 1ns/1ps

module seq_decode (
    input  logic [dsp_seq_pkg::word_w-1:0] inst,
    seq_ctl_if.dec                         ctl
);

    logic [3:0] op;
    logic [2:0] br;

    assign op = inst[dsp_seq_pkg::op_hi:dsp_seq_pkg::op_lo];
    assign br = inst[dsp_seq_pkg::br_hi:dsp_seq_pkg::br_lo];

    // Fields are passed on for every opcode, strobes qualify them
    assign ctl.ja_field = inst[dsp_seq_pkg::ja_w-1:0];
    assign ctl.r_field  = inst[dsp_seq_pkg::rsel_hi:dsp_seq_pkg::rsel_lo];

    // Sign-extended load immediate
    assign ctl.imm = {{(dsp_seq_pkg::word_w - dsp_seq_pkg::imm_w){inst[dsp_seq_pkg::imm_w-1]}},
                      inst[dsp_seq_pkg::imm_w-1:0]};

    always_comb begin
        ctl.goto_ja = 1'b0;
        ctl.call_ja = 1'b0;
        ctl.ret     = 1'b0;
        ctl.iret    = 1'b0;
        ctl.goto_pt = 1'b0;
        ctl.call_pt = 1'b0;
        ctl.load_en = 1'b0;
        ctl.pt_read = 1'b0;
        ctl.istep   = 1'b0;
        case (op)
            dsp_seq_pkg::op_nop: begin
                // Sequential fetch only
            end
            dsp_seq_pkg::op_goto: begin
                ctl.goto_ja = 1'b1;
            end
            dsp_seq_pkg::op_call: begin
                ctl.call_ja = 1'b1;
            end
            dsp_seq_pkg::op_branch: begin
                case (br)
                    dsp_seq_pkg::br_ret:     ctl.ret     = 1'b1;
                    dsp_seq_pkg::br_iret:    ctl.iret    = 1'b1;
                    dsp_seq_pkg::br_goto_pt: ctl.goto_pt = 1'b1;
                    dsp_seq_pkg::br_call_pt: ctl.call_pt = 1'b1;
                    // Unused branch codes behave as nop
                    default: ;
                endcase
            end
            dsp_seq_pkg::op_load: begin
                ctl.load_en = 1'b1;
            end
            dsp_seq_pkg::op_ptread: begin
                ctl.pt_read = 1'b1;
                ctl.istep   = inst[dsp_seq_pkg::istep_bit];
            end
            default: ;
        endcase
    end

    // Address unit relies on exclusive strobes for its priority chain
    always_comb begin
        if (!$isunknown(inst)) begin
            assert ($onehot0({ctl.goto_ja, ctl.call_ja, ctl.ret, ctl.iret,
                              ctl.goto_pt, ctl.call_pt, ctl.load_en, ctl.pt_read}))
            else $error("seq_decode: several strobes for word %h", inst);
        end
    end

endmodule

// File: src/seq_rom_aau.sv
`timescale 1ns/1ps

module seq_rom_aau (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           cen,
    input  logic                           irq,
    seq_ctl_if.aau                         ctl,
    output logic [dsp_seq_pkg::addr_w-1:0] rom_addr,
    output logic [dsp_seq_pkg::addr_w-1:0] pt_addr,
    input  logic [dsp_seq_pkg::word_w-1:0] tab_data,
    output logic [dsp_seq_pkg::word_w-1:0] pt_data,
    output logic                           pt_data_valid
);

    // Program counter, return, interrupt return and table pointer
    logic [dsp_seq_pkg::addr_w-1:0] pc;
    logic [dsp_seq_pkg::addr_w-1:0] pr;
    logic [dsp_seq_pkg::addr_w-1:0] pi;
    logic [dsp_seq_pkg::addr_w-1:0] pt;
    logic [dsp_seq_pkg::step_w-1:0] step;
    logic                           in_irq;

    logic                           take_irq;
    logic                           tab_fire;
    logic [dsp_seq_pkg::addr_w-1:0] seq_pc;
    logic [dsp_seq_pkg::addr_w-1:0] next_pc;
    logic [dsp_seq_pkg::addr_w-1:0] next_pt;
    logic [dsp_seq_pkg::addr_w-1:0] step_ext;

    assign seq_pc   = pc + 1'b1;
    assign step_ext = {{(dsp_seq_pkg::addr_w - dsp_seq_pkg::step_w){step[dsp_seq_pkg::step_w-1]}},
                       step};
    assign next_pt  = pt + (ctl.istep ? step_ext : {{(dsp_seq_pkg::addr_w-1){1'b0}}, 1'b1});

    // A request inside the handler is lost
    assign take_irq = irq && !in_irq;

    // Table read that really executes at this edge
    assign tab_fire = cen && !take_irq && ctl.pt_read;

    assign rom_addr = pc;
    assign pt_addr  = pt;

    // Next PC priority is irq, then absolute, pointer and return
    always_comb begin
        if (take_irq) begin
            next_pc = dsp_seq_pkg::irq_vector;
        end else if (ctl.goto_ja || ctl.call_ja) begin
            next_pc = {pc[dsp_seq_pkg::addr_w-1:dsp_seq_pkg::ja_w], ctl.ja_field};
        end else if (ctl.goto_pt || ctl.call_pt) begin
            next_pc = pt;
        end else if (ctl.ret) begin
            next_pc = pr;
        end else if (ctl.iret) begin
            next_pc = pi;
        end else begin
            next_pc = seq_pc;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            pc     <= dsp_seq_pkg::reset_pc;
            pr     <= '0;
            pi     <= '0;
            pt     <= '0;
            step   <= '0;
            in_irq <= 1'b0;
        end else if (cen) begin
            pc <= next_pc;
            if (take_irq) begin
                // Fetched word is dropped and runs again after iret
                pi     <= pc;
                in_irq <= 1'b1;
            end else begin
                if (ctl.iret) begin
                    in_irq <= 1'b0;
                end
                if (ctl.call_ja || ctl.call_pt) begin
                    pr <= seq_pc;
                end
                if (ctl.load_en) begin
                    case (ctl.r_field)
                        dsp_seq_pkg::reg_pt: pt   <= ctl.imm;
                        dsp_seq_pkg::reg_pr: pr   <= ctl.imm;
                        dsp_seq_pkg::reg_pi: pi   <= ctl.imm;
                        dsp_seq_pkg::reg_i:  step <= ctl.imm[dsp_seq_pkg::step_w-1:0];
                    endcase
                end
                if (ctl.pt_read) begin
                    pt <= next_pt;
                end
            end
        end
    end

    // Table data capture with a one-cycle valid strobe
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            pt_data       <= '0;
            pt_data_valid <= 1'b0;
        end else begin
            pt_data_valid <= tab_fire;
            if (tab_fire) begin
                pt_data <= tab_data;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) !$isunknown(pc))
    else $error("seq_rom_aau: pc unknown");

    // A request inside the handler must not overwrite the saved return
    assert property (@(posedge clk) disable iff (rst)
        (cen && irq && in_irq) |=>
            ($stable(pi) || $past(ctl.load_en && ctl.r_field == dsp_seq_pkg::reg_pi)))
    else $error("seq_rom_aau: nested irq taken");

    // Valid may only repeat when the sequencer advanced to a new word
    assert property (@(posedge clk) disable iff (rst)
        pt_data_valid |=> (!pt_data_valid || pc != $past(pc)))
    else $error("seq_rom_aau: pt_data_valid held without a read");

endmodule

// File: src/seq_top.sv
`timescale 1ns/1ps

module seq_top (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           cen,
    input  logic                           irq,
    output logic [dsp_seq_pkg::addr_w-1:0] pc,
    output logic [dsp_seq_pkg::word_w-1:0] pt_data,
    output logic                           pt_data_valid
);

    logic [dsp_seq_pkg::word_w-1:0] inst_data;
    logic [dsp_seq_pkg::addr_w-1:0] tab_addr;
    logic [dsp_seq_pkg::word_w-1:0] tab_data;

    // Decoder to address unit controls
    seq_ctl_if ctl_i ();

    // Program counter drives the instruction port directly
    seq_prog_rom seq_prog_rom_i (
        .inst_addr (pc),
        .inst_data (inst_data),
        .tab_addr  (tab_addr),
        .tab_data  (tab_data)
    );

    seq_decode seq_decode_i (
        .inst (inst_data),
        .ctl  (ctl_i.dec)
    );

    seq_rom_aau seq_rom_aau_i (
        .clk           (clk),
        .rst           (rst),
        .cen           (cen),
        .irq           (irq),
        .ctl           (ctl_i.aau),
        .rom_addr      (pc),
        .pt_addr       (tab_addr),
        .tab_data      (tab_data),
        .pt_data       (pt_data),
        .pt_data_valid (pt_data_valid)
    );

endmodule

// File: sim/seq_checker.sv
`timescale 1ns/1ps

module seq_checker (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           cen,
    input  logic                           irq,
    input  logic [dsp_seq_pkg::addr_w-1:0] pc,
    input  logic [dsp_seq_pkg::word_w-1:0] pt_data,
    input  logic                           pt_data_valid,
    output int                             errors,
    output int                             pulses
);

    // Architectural state of the sequencer plus the registered table outputs
    typedef struct packed {
        logic [15:0] pc, pr, pi, pt;
        logic [11:0] step;
        logic        in_irq;
        logic [15:0] data;
        logic        valid;
    } model_t;

    logic [dsp_seq_pkg::word_w-1:0] mem [dsp_seq_pkg::rom_depth];
    model_t                         m;

    initial begin
        errors = 0;
        pulses = 0;
        $readmemh("program.hex", mem);
    end

    // One rising edge of the sequencer
    function automatic model_t step_model(model_t s, logic en, logic req);
        model_t      n;
        logic [15:0] w;
        logic [15:0] imm;
        logic [15:0] ja;
        n = s;
        n.valid = 1'b0;
        w = mem[s.pc[11:0]];
        imm = {{6{w[9]}}, w[9:0]};
        ja = {s.pc[15:12], w[11:0]};
        if (!en) begin
            // Everything holds, valid drops
        end else if (req && !s.in_irq) begin
            n.pc = dsp_seq_pkg::irq_vector;
            n.pi = s.pc;
            n.in_irq = 1'b1;
        end else begin
            n.pc = s.pc + 16'd1;
            case (w[15:12])
                dsp_seq_pkg::op_goto: n.pc = ja;
                dsp_seq_pkg::op_call: begin
                    n.pc = ja;
                    n.pr = s.pc + 16'd1;
                end
                dsp_seq_pkg::op_branch: begin
                    case (w[10:8])
                        dsp_seq_pkg::br_ret:     n.pc = s.pr;
                        dsp_seq_pkg::br_goto_pt: n.pc = s.pt;
                        dsp_seq_pkg::br_iret: begin
                            n.pc = s.pi;
                            n.in_irq = 1'b0;
                        end
                        dsp_seq_pkg::br_call_pt: begin
                            n.pc = s.pt;
                            n.pr = s.pc + 16'd1;
                        end
                        default: ;
                    endcase
                end
                dsp_seq_pkg::op_load: begin
                    case (w[11:10])
                        dsp_seq_pkg::reg_pt: n.pt = imm;
                        dsp_seq_pkg::reg_pr: n.pr = imm;
                        dsp_seq_pkg::reg_pi: n.pi = imm;
                        default:             n.step = imm[11:0];
                    endcase
                end
                dsp_seq_pkg::op_ptread: begin
                    // Word at the old pointer
                    n.data = mem[s.pt[11:0]];
                    n.valid = 1'b1;
                    n.pt = s.pt + (w[0] ? {{4{s.step[11]}}, s.step} : 16'd1);
                end
                default: ;
            endcase
        end
        return n;
    endfunction

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            m <= '0;
            m.pc <= dsp_seq_pkg::reset_pc;
        end else begin
            m <= step_model(m, cen, irq);
        end
    end

    // Outputs are long settled at the falling edge
    always @(negedge clk) begin
        if (pc !== m.pc) begin
            errors++;
            $display("error at %0t: pc expected %h, got %h", $time, m.pc, pc);
        end
        if (pt_data_valid !== m.valid) begin
            errors++;
            $display("error at %0t: pt_data_valid expected %b, got %b",
                     $time, m.valid, pt_data_valid);
        end
        if (pt_data !== m.data) begin
            errors++;
            $display("error at %0t: pt_data expected %h, got %h", $time, m.data, pt_data);
        end
        if (pt_data_valid === 1'b1) begin
            pulses++;
        end
    end

endmodule

// File: sim/seq_tb.sv
`timescale 1ns/1ps

module seq_tb;

    localparam int wait_limit = 400;

    logic                           clk = 1'b0;
    logic                           rst;
    logic                           cen;
    logic                           irq;
    logic [dsp_seq_pkg::addr_w-1:0] pc;
    logic [dsp_seq_pkg::word_w-1:0] pt_data;
    logic                           pt_data_valid;
    logic                           cen_gaps = 1'b0;
    logic                           random_irq = 1'b0;
    logic                           irq_once = 1'b0;
    int                             errors;
    int                             pulses;
    int                             own_errs = 0;
    int                             err_mark = 0;
    int                             failed = 0;
    int                             total = 0;
    int                             vector_hits = 0;

    seq_top seq_top_i (.*);

    seq_checker checker_i (.*);

    always #50 clk = ~clk;

    // Drive just after the rising edge, sample after the falling edge
    task automatic tick();
        @(posedge clk);
        #5;
        cen = cen_gaps ? ($urandom % 4 != 0) : 1'b1;
        irq = irq_once || (random_irq && ($urandom % 12 == 0));
        irq_once = 1'b0;
        @(negedge clk);
        #1;
        if (pc == dsp_seq_pkg::irq_vector) begin
            vector_hits++;
        end
    endtask

    task automatic wait_pc(input logic [15:0] target);
        int n;
        n = 0;
        tick();
        while (pc !== target && n < wait_limit) begin
            tick();
            n++;
        end
        if (pc !== target) begin
            own_errs++;
            $display("timeout: pc did not reach %h within %0d cycles", target, wait_limit);
        end
    endtask

    task automatic finish_test(input int num, input string name);
        int n;
        n = errors - err_mark + own_errs;
        if (n != 0) begin
            failed++;
        end
        total += n;
        $display("test %0d %s: %s, %0d errors", num, name, (n == 0) ? "ok" : "failed", n);
        err_mark = errors;
        own_errs = 0;
    endtask

    initial begin
        logic [15:0] saved;
        int          n;
        void'($urandom(32'h853c_46a9));
        rst = 1'b1;
        cen = 1'b0;
        irq = 1'b0;
        repeat (10) @(posedge clk);
        #5;
        rst = 1'b0;

        wait_pc(16'h000b);
        finish_test(1, "sequential code, goto, call and return");
        wait_pc(16'h0016);
        finish_test(2, "register loads and pointer branches");

        n = pulses;
        wait_pc(16'h001f);
        if (pulses - n != 5) begin
            own_errs++;
            $display("table reads gave %0d valid pulses instead of 5", pulses - n);
        end
        finish_test(3, "table reads with and without step");

        cen_gaps = 1'b1;
        repeat (2) begin
            wait_pc(16'h0006);
            wait_pc(16'h001f);
        end
        cen_gaps = 1'b0;
        finish_test(4, "random clock enable gaps");

        vector_hits = 0;
        random_irq = 1'b1;
        repeat (3) begin
            wait_pc(16'h0006);
            wait_pc(16'h001f);
        end
        random_irq = 1'b0;
        wait_pc(16'h0006);
        if (vector_hits == 0) begin
            own_errs++;
            $display("no random interrupt ever reached the vector");
        end
        // Directed entry, then a second request inside the handler
        irq_once = 1'b1;
        tick();
        saved = pc;
        tick();
        if (pc !== dsp_seq_pkg::irq_vector) begin
            own_errs++;
            $display("error at %0t: pc expected %h, got %h", $time, dsp_seq_pkg::irq_vector, pc);
        end
        irq_once = 1'b1;
        tick();
        n = 0;
        tick();
        while (pc >= dsp_seq_pkg::irq_vector && pc <= dsp_seq_pkg::irq_vector + 16'd2
               && n < wait_limit) begin
            tick();
            n++;
        end
        if (pc !== saved) begin
            own_errs++;
            $display("error at %0t: pc expected %h, got %h", $time, saved, pc);
        end
        finish_test(5, "interrupt entry, nested request and iret");

        n = 0;
        tick();
        while (pt_data_valid !== 1'b1 && n < wait_limit) begin
            tick();
            n++;
        end
        if (pt_data_valid !== 1'b1) begin
            own_errs++;
            $display("timeout: no table read seen before the mid-run reset");
        end
        @(posedge clk);
        #5;
        rst = 1'b1;
        @(negedge clk);
        #1;
        if (pc !== dsp_seq_pkg::reset_pc || pt_data_valid !== 1'b0) begin
            own_errs++;
            $display("error at %0t: pc expected %h, got %h; pt_data_valid expected 0, got %b",
                     $time, dsp_seq_pkg::reset_pc, pc, pt_data_valid);
        end
        repeat (3) tick();
        @(posedge clk);
        #5;
        rst = 1'b0;
        wait_pc(16'h000b);
        finish_test(6, "reset in mid-run");

        $display("tests run 6, tests failed %0d, errors %0d", failed, total);
        if (failed == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: program.hex
// One 16-bit word per line in hex, @ lines set the word address
// Top digit is the opcode: 0 nop, 1 goto, 2 call, 3 branch, 4 load, 5 table read
@000
1004
0000
0000
3100
4806
3100
0000
2009
100B
0000
3000
400E
3300
1010
3000
0000
4013
3200
0000
4416
3000
0000
4100
4C02
5000
5001
4FFF
5001
5000
4300
5000
1006
@100
1234
ABCD
8001
7FFE
@F00
C0DE

// File: src.f
src/dsp_seq_pkg.sv
src/seq_ctl_if.sv
src/seq_prog_rom.sv
src/seq_decode.sv
src/seq_rom_aau.sv
src/seq_top.sv
sim/seq_checker.sv
sim/seq_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the sequencer testbench with Verilator and run it from the project root
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f src.f --top-module seq_tb -o seq_sim

./obj_dir/seq_sim | tee sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
